// File: verification/csr_unit_trace.txt
# cmd_v op addr data exc_v exc_dec exc_pc irq_pc ext sw tim instret exp_data exp_ill exp_trap exp_ret
# All hex, op 0 rw 1 rs 2 rc 3 rwi 4 rsi 5 rci 6 mret, one line per clock cycle
# mscratch read-modify-write
1 0 340 123456789abcdef0 0 000 0 0 0 0 0 0 0 0 0 0
1 1 340 0f00 0 000 0 0 0 0 0 0 123456789abcdef0 0 0 0
1 2 340 ff00000000000000 0 000 0 0 0 0 0 0 123456789abcdff0 0 0 0
1 3 340 35 0 000 0 0 0 0 0 0 003456789abcdff0 0 0 0
1 4 340 0a 0 000 0 0 0 0 0 0 15 0 0 0
1 5 340 03 0 000 0 0 0 0 0 0 1f 0 0 0
1 1 340 0 0 000 0 0 0 0 0 0 1c 0 0 0
# Unknown address and mhartid
1 1 7c0 0 0 000 0 0 0 0 0 0 0 1 0 0
1 1 f14 0 0 000 0 0 0 0 0 0 a 0 0 0
# Exception in M mode, then mcause, mepc and mtval
0 0 340 0 1 024 80001000 0 0 0 0 0 1c 0 1 0
1 1 342 0 0 000 0 0 0 0 0 0 2 0 0 0
1 1 341 0 0 000 0 0 0 0 0 0 80001000 0 0 0
1 1 343 0 0 000 0 0 0 0 0 0 80001000 0 0 0
# Clear mpp, mret to U, mret in U is illegal
1 2 300 1800 0 000 0 0 0 0 0 0 1800 0 0 0
1 6 300 0 0 000 0 0 0 0 0 0 0 0 0 1
1 6 300 0 0 000 0 0 0 0 0 0 80 1 0 0
# ecall from U
0 0 340 0 1 100 80002000 0 0 0 0 0 1c 0 1 0
1 1 342 0 0 000 0 0 0 0 0 0 8 0 0 0
1 1 341 0 0 000 0 0 0 0 0 0 80002000 0 0 0
1 6 300 0 0 000 0 0 0 0 0 0 0 0 0 1
1 1 340 0 0 000 0 0 0 0 0 0 1c 1 0 0
0 0 340 0 1 100 80003000 0 0 0 0 0 1c 0 1 0
# Enable meip and mtip, then external and timer together with an exception
1 0 304 880 0 000 0 0 0 0 0 0 0 0 0 0
1 4 300 8 0 000 0 0 1 0 1 0 0 0 0 0
0 0 340 0 1 004 80004000 80005000 1 0 1 0 1c 0 1 0
1 1 342 0 0 000 0 0 1 0 1 0 800000000000000b 0 0 0
1 1 341 0 0 000 0 0 1 0 1 0 80004000 0 0 0
1 1 343 0 0 000 0 0 1 0 1 0 0 0 0 0
1 1 300 0 0 000 0 0 0 0 0 0 1880 0 0 0
# mcycle write and minstret counting
1 0 b00 1000 0 000 0 0 0 0 0 0 1d 0 0 0
1 1 b00 0 0 000 0 0 0 0 0 0 1000 0 0 0
1 1 b02 0 0 000 0 0 0 0 0 1 0 0 0 0
1 1 b00 0 0 000 0 0 0 0 0 0 1002 0 0 0
1 1 b02 0 0 000 0 0 0 0 0 1 1 0 0 0
1 1 b02 0 0 000 0 0 0 0 0 0 2 0 0 0
1 1 b00 0 0 000 0 0 0 0 0 0 1005 0 0 0

// File: files.f
src/riscv_priv_pkg.sv
src/csr_unit_pkg.sv
src/csr_trap_cause.sv
src/csr_priv_fsm.sv
src/csr_counters.sv
src/csr_regfile.sv
src/csr_unit.sv
verification/tb_clock_gen.sv
verification/tb_csr_unit.sv

// File: Makefile
VERILATOR  := verilator
TOP        := tb_csr_unit
FILE_LIST  := files.f
COMMON     := --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FILE_LIST)
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary $(COMMON) --Mdir obj_dir
SIM_BIN    := obj_dir/V$(TOP)
LOG        := sim.log
PASS_TEXT  := NO ERRORS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS)

sim:
	$(VERILATOR) $(SIM_FLAGS)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/tb_csr_unit.sv
module tb_csr_unit;
    timeunit 1ns;
    timeprecision 100ps;

    import riscv_priv_pkg::*;
    import csr_unit_pkg::*;

    localparam string TRACE_FILE    = "verification/csr_unit_trace.txt";
    localparam int    RESET_CYCLES  = 8;
    localparam int    TRACE_COLUMNS = 16;
    localparam int    CHECK_DELAY   = 2;
    localparam int    TIMEOUT_SLACK = 20;

    // One cycle of stimulus and the responses expected in that cycle
    typedef struct packed {
        logic        cmd_v;
        logic [2:0]  op;
        logic [11:0] addr;
        logic [63:0] data;
        logic        exc_v;
        logic [11:0] exc_dec;
        logic [63:0] exc_pc;
        logic [63:0] irq_pc;
        logic        ext_int;
        logic        sw_int;
        logic        tim_int;
        logic        instret;
        logic [63:0] exp_data;
        logic        exp_ill;
        logic        exp_trap;
        logic        exp_ret;
    } trace_line_s;

    logic            clk;
    logic            reset;
    logic            csr_cmd_v;
    csr_cmd_s        csr_cmd;
    logic            exc_v;
    exc_dec_s        exc_dec;
    logic [XLEN-1:0] exc_pc;
    logic [XLEN-1:0] irq_pc;
    logic            timer_int;
    logic            software_int;
    logic            external_int;
    logic            instret;
    logic [3:0]      hartid;
    logic [XLEN-1:0] data;
    logic            v;
    logic            illegal_instr;
    logic            trap_v;
    logic            ret_v;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] exp_mtvec = '0;
    trace_line_s     trace [$];
    int              error_count = 0;
    int              cycle_count = 0;
    int              cycle_limit = 0;

    tb_clock_gen #(.PERIOD(8)) i_clock_gen
    (
        .clk_o (clk)
    );

    csr_unit i_csr_unit
    (
        .clk_i           (clk),
        .reset_i         (reset),
        .csr_cmd_v_i     (csr_cmd_v),
        .csr_cmd_i       (csr_cmd),
        .exc_v_i         (exc_v),
        .exc_dec_i       (exc_dec),
        .exc_pc_i        (exc_pc),
        .irq_pc_i        (irq_pc),
        .timer_int_i     (timer_int),
        .software_int_i  (software_int),
        .external_int_i  (external_int),
        .instret_i       (instret),
        .hartid_i        (hartid),
        .data_o          (data),
        .v_o             (v),
        .illegal_instr_o (illegal_instr),
        .trap_v_o        (trap_v),
        .ret_v_o         (ret_v),
        .mepc_o          (mepc),
        .mtvec_o         (mtvec)
    );

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic compare_value(int line_no, string what, logic [63:0] got,
                                 logic [63:0] expected);
        if (got !== expected)
        begin
            error_count++;
            abort_run($sformatf("[FAIL] %0t ns: trace line %0d, %s is %h, expected %h",
                                $time, line_no, what, got, expected));
        end
    endtask

    // Write, set and clear, with the immediate forms taking 5 operand bits
    function automatic logic [63:0] rmw_result(logic [2:0] op, logic [63:0] old_value,
                                               logic [63:0] operand);
        logic [63:0] imm;
        imm = {59'd0, operand[4:0]};
        case (op)
            e_csrrw:  return operand;
            e_csrrs:  return old_value | operand;
            e_csrrc:  return old_value & ~operand;
            e_csrrwi: return imm;
            e_csrrsi: return old_value | imm;
            e_csrrci: return old_value & ~imm;
            default:  return old_value;
        endcase
    endfunction

    task automatic load_trace();
        int          fd;
        int          fields;
        string       text;
        logic [63:0] f [TRACE_COLUMNS];
        trace_line_s entry;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0)
            abort_run($sformatf("Cannot open the trace file %s", TRACE_FILE));
        while ($fgets(text, fd) != 0)
        begin
            if (text.len() < 2 || text[0] == "#")
                continue;
            fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                             f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
            if (fields != TRACE_COLUMNS)
                abort_run($sformatf("Malformed line in the trace file: %s", text));
            entry.cmd_v    = f[0][0];
            entry.op       = f[1][2:0];
            entry.addr     = f[2][11:0];
            entry.data     = f[3];
            entry.exc_v    = f[4][0];
            entry.exc_dec  = f[5][11:0];
            entry.exc_pc   = f[6];
            entry.irq_pc   = f[7];
            entry.ext_int  = f[8][0];
            entry.sw_int   = f[9][0];
            entry.tim_int  = f[10][0];
            entry.instret  = f[11][0];
            entry.exp_data = f[12];
            entry.exp_ill  = f[13][0];
            entry.exp_trap = f[14][0];
            entry.exp_ret  = f[15][0];
            trace.push_back(entry);
        end
        $fclose(fd);
        if (trace.size() == 0)
            abort_run("The trace file holds no stimulus lines");
    endtask

    task automatic apply_line(trace_line_s e);
        csr_cmd_v    = e.cmd_v;
        csr_cmd.op   = csr_op_e'(e.op);
        csr_cmd.addr = e.addr;
        csr_cmd.data = e.data;
        exc_v        = e.exc_v;
        exc_dec      = exc_dec_s'(e.exc_dec);
        exc_pc       = e.exc_pc;
        irq_pc       = e.irq_pc;
        external_int = e.ext_int;
        software_int = e.sw_int;
        timer_int    = e.tim_int;
        instret      = e.instret;
    endtask

    task automatic check_line(int line_no, trace_line_s e);
        compare_value(line_no, "data_o", data, e.exp_data);
        compare_value(line_no, "v_o", 64'(v), 64'(e.cmd_v));
        compare_value(line_no, "illegal_instr_o", 64'(illegal_instr), 64'(e.exp_ill));
        compare_value(line_no, "trap_v_o", 64'(trap_v), 64'(e.exp_trap));
        compare_value(line_no, "ret_v_o", 64'(ret_v), 64'(e.exp_ret));
        compare_value(line_no, "mtvec_o", mtvec, exp_mtvec);
        // A line that addresses mepc carries its expected value
        if (e.addr == CSR_ADDR_MEPC)
            compare_value(line_no, "mepc_o", mepc, e.exp_data);
    endtask

    // Illegal commands leave mtvec unchanged
    task automatic track_mtvec(trace_line_s e);
        if (e.cmd_v && e.addr == CSR_ADDR_MTVEC && e.op != e_mret && !e.exp_ill)
            exp_mtvec = rmw_result(e.op, exp_mtvec, e.data);
    endtask

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count > cycle_limit)
            abort_run($sformatf("Timeout, the run went past %0d clock cycles", cycle_limit));
    end

    initial
    begin
        trace_line_s idle;
        idle = '0;
        apply_line(idle);
        hartid = 4'ha;
        reset  = 1'b1;
        load_trace();
        cycle_limit = trace.size() + TIMEOUT_SLACK;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < trace.size(); i++)
        begin
            apply_line(trace[i]);
            #(CHECK_DELAY);
            check_line(i, trace[i]);
            track_mtvec(trace[i]);
            @(negedge clk);
        end
        if (error_count == 0)
        begin
            $display("NO ERRORS");
            $finish;
        end
        else
        begin
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

endmodule

// File: verification/tb_clock_gen.sv
module tb_clock_gen
#(
    parameter int PERIOD = 8
)
(
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk_o = 1'b0;
        forever
        begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

endmodule

// File: src/csr_unit.sv
module csr_unit
#(
    parameter int unsigned CNT_WIDTH = 64,
    parameter int unsigned HART_BITS = 4
)
(
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  logic                             csr_cmd_v_i,
    input  csr_unit_pkg::csr_cmd_s           csr_cmd_i,
    input  logic                             exc_v_i,
    input  csr_unit_pkg::exc_dec_s           exc_dec_i,
    input  logic [riscv_priv_pkg::XLEN-1:0]  exc_pc_i,
    input  logic [riscv_priv_pkg::XLEN-1:0]  irq_pc_i,
    input  logic                             timer_int_i,
    input  logic                             software_int_i,
    input  logic                             external_int_i,
    input  logic                             instret_i,
    input  logic [HART_BITS-1:0]             hartid_i,
    output logic [riscv_priv_pkg::XLEN-1:0]  data_o,
    output logic                             v_o,
    output logic                             illegal_instr_o,
    output logic                             trap_v_o,
    output logic                             ret_v_o,
    output logic [riscv_priv_pkg::XLEN-1:0]  mepc_o,
    output logic [riscv_priv_pkg::XLEN-1:0]  mtvec_o
);
    import riscv_priv_pkg::*;
    import csr_unit_pkg::*;

    trap_req_s            trap_req;
    priv_mode_e           priv_mode;
    mstatus_s             mstatus;
    mirq_s                mie, mip;
    logic [XLEN-1:0]      wdata;
    logic                 mstatus_we, cycle_we, instret_we, addr_bad;
    logic [CNT_WIDTH-1:0] cycle_cnt, instret_cnt;

    assign v_o = csr_cmd_v_i;

    csr_trap_cause i_trap_cause
    (
        .priv_mode_i (priv_mode),
        .mstatus_i   (mstatus),
        .mie_i       (mie),
        .mip_i       (mip),
        .exc_v_i     (exc_v_i),
        .exc_dec_i   (exc_dec_i),
        .exc_pc_i    (exc_pc_i),
        .irq_pc_i    (irq_pc_i),
        .trap_req_o  (trap_req)
    );

    csr_priv_fsm i_priv_fsm
    (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .csr_cmd_v_i     (csr_cmd_v_i),
        .csr_op_i        (csr_cmd_i.op),
        .trap_req_i      (trap_req),
        .mstatus_we_i    (mstatus_we),
        .wdata_i         (wdata),
        .addr_bad_i      (addr_bad),
        .priv_mode_o     (priv_mode),
        .mstatus_o       (mstatus),
        .trap_v_o        (trap_v_o),
        .ret_v_o         (ret_v_o),
        .illegal_instr_o (illegal_instr_o)
    );

    csr_counters #(.CNT_WIDTH(CNT_WIDTH)) i_counters
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instret_i     (instret_i),
        .cycle_we_i    (cycle_we),
        .instret_we_i  (instret_we),
        .wdata_i       (wdata[CNT_WIDTH-1:0]),
        .cycle_cnt_o   (cycle_cnt),
        .instret_cnt_o (instret_cnt)
    );

    csr_regfile #(.CNT_WIDTH(CNT_WIDTH), .HART_BITS(HART_BITS)) i_regfile
    (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .csr_cmd_v_i    (csr_cmd_v_i),
        .csr_cmd_i      (csr_cmd_i),
        .hartid_i       (hartid_i),
        .timer_int_i    (timer_int_i),
        .software_int_i (software_int_i),
        .external_int_i (external_int_i),
        .trap_req_i     (trap_req),
        .priv_mode_i    (priv_mode),
        .mstatus_i      (mstatus),
        .cycle_cnt_i    (cycle_cnt),
        .instret_cnt_i  (instret_cnt),
        .data_o         (data_o),
        .wdata_o        (wdata),
        .mstatus_we_o   (mstatus_we),
        .cycle_we_o     (cycle_we),
        .instret_we_o   (instret_we),
        .addr_bad_o     (addr_bad),
        .mie_o          (mie),
        .mip_o          (mip),
        .mepc_o         (mepc_o),
        .mtvec_o        (mtvec_o)
    );

endmodule

// File: src/csr_regfile.sv
module csr_regfile
#(
    parameter int unsigned CNT_WIDTH = 64,
    parameter int unsigned HART_BITS = 4
)
(
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  logic                             csr_cmd_v_i,
    input  csr_unit_pkg::csr_cmd_s           csr_cmd_i,
    input  logic [HART_BITS-1:0]             hartid_i,
    input  logic                             timer_int_i,
    input  logic                             software_int_i,
    input  logic                             external_int_i,
    input  csr_unit_pkg::trap_req_s          trap_req_i,
    input  riscv_priv_pkg::priv_mode_e       priv_mode_i,
    input  riscv_priv_pkg::mstatus_s         mstatus_i,
    input  logic [CNT_WIDTH-1:0]             cycle_cnt_i,
    input  logic [CNT_WIDTH-1:0]             instret_cnt_i,
    output logic [riscv_priv_pkg::XLEN-1:0]  data_o,
    output logic [riscv_priv_pkg::XLEN-1:0]  wdata_o,
    output logic                             mstatus_we_o,
    output logic                             cycle_we_o,
    output logic                             instret_we_o,
    output logic                             addr_bad_o,
    output riscv_priv_pkg::mirq_s            mie_o,
    output riscv_priv_pkg::mirq_s            mip_o,
    output logic [riscv_priv_pkg::XLEN-1:0]  mepc_o,
    output logic [riscv_priv_pkg::XLEN-1:0]  mtvec_o
);
    import riscv_priv_pkg::*;
    import csr_unit_pkg::*;

    localparam logic [11:0] MIRQ_MASK = 12'h888;

    logic [XLEN-1:0] operand, rdata, wdata;
    logic [XLEN-1:0] mtvec_r, mscratch_r, mepc_r, mtval_r;
    mcause_s         mcause_r;
    mirq_s           mie_r, mip_r;
    logic            known, is_imm, is_mret, wr_req;

    assign is_mret = csr_cmd_i.op == e_mret;
    assign is_imm  = csr_cmd_i.op inside {e_csrrwi, e_csrrsi, e_csrrci};
    assign operand = is_imm ? XLEN'(csr_cmd_i.data[4:0]) : csr_cmd_i.data;

    // Set and clear with a zero operand leave the register alone
    assign wr_req = csr_cmd_v_i & ~is_mret & known & (priv_mode_i == PRIV_M)
                  & ((csr_cmd_i.op inside {e_csrrw, e_csrrwi}) | (|operand));

    always_comb
    begin
        known = 1'b1;
        case (csr_cmd_i.addr)
            CSR_ADDR_MSTATUS:  rdata = XLEN'(mstatus_i);
            CSR_ADDR_MIE:      rdata = XLEN'(mie_r);
            CSR_ADDR_MIP:      rdata = XLEN'(mip_r);
            CSR_ADDR_MTVEC:    rdata = mtvec_r;
            CSR_ADDR_MSCRATCH: rdata = mscratch_r;
            CSR_ADDR_MEPC:     rdata = mepc_r;
            CSR_ADDR_MCAUSE:   rdata = mcause_r;
            CSR_ADDR_MTVAL:    rdata = mtval_r;
            CSR_ADDR_MCYCLE:   rdata = XLEN'(cycle_cnt_i);
            CSR_ADDR_MINSTRET: rdata = XLEN'(instret_cnt_i);
            CSR_ADDR_MHARTID:  rdata = XLEN'(hartid_i);
            default:
            begin
                rdata = '0;
                known = 1'b0;
            end
        endcase
    end

    always_comb
    begin
        case (csr_cmd_i.op)
            e_csrrw, e_csrrwi: wdata = operand;
            e_csrrs, e_csrrsi: wdata = rdata | operand;
            e_csrrc, e_csrrci: wdata = rdata & ~operand;
            default:           wdata = rdata;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            mie_r      <= '0;
            mip_r      <= '0;
            mtvec_r    <= '0;
            mscratch_r <= '0;
            mepc_r     <= '0;
            mcause_r   <= '0;
            mtval_r    <= '0;
        end
        else
        begin
            mip_r.meip <= external_int_i;
            mip_r.mtip <= timer_int_i;
            mip_r.msip <= software_int_i;
            if (wr_req && csr_cmd_i.addr == CSR_ADDR_MIE)
                mie_r <= wdata[11:0] & MIRQ_MASK;
            if (wr_req && csr_cmd_i.addr == CSR_ADDR_MTVEC)
                mtvec_r <= wdata;
            if (wr_req && csr_cmd_i.addr == CSR_ADDR_MSCRATCH)
                mscratch_r <= wdata;
            // Trap state beats a software write in the same cycle
            if (trap_req_i.valid)
            begin
                mepc_r             <= trap_req_i.epc;
                mtval_r            <= trap_req_i.tval;
                mcause_r.interrupt <= trap_req_i.interrupt;
                mcause_r.code      <= trap_req_i.code;
            end
            else
            begin
                if (wr_req && csr_cmd_i.addr == CSR_ADDR_MEPC)
                    mepc_r <= wdata;
                if (wr_req && csr_cmd_i.addr == CSR_ADDR_MTVAL)
                    mtval_r <= wdata;
                if (wr_req && csr_cmd_i.addr == CSR_ADDR_MCAUSE)
                begin
                    mcause_r.interrupt <= wdata[XLEN-1];
                    mcause_r.code      <= wdata[3:0];
                end
            end
        end
    end

    // Every CSR here is M-mode, so U mode may access none of them
    assign addr_bad_o   = csr_cmd_v_i & ~is_mret & (~known | (priv_mode_i != PRIV_M));
    assign mstatus_we_o = wr_req & (csr_cmd_i.addr == CSR_ADDR_MSTATUS);
    assign cycle_we_o   = wr_req & (csr_cmd_i.addr == CSR_ADDR_MCYCLE);
    assign instret_we_o = wr_req & (csr_cmd_i.addr == CSR_ADDR_MINSTRET);

    assign data_o  = rdata;
    assign wdata_o = wdata;
    assign mie_o   = mie_r;
    assign mip_o   = mip_r;
    assign mepc_o  = mepc_r;
    assign mtvec_o = mtvec_r;

endmodule

// File: src/csr_counters.sv
module csr_counters
#(
    parameter int unsigned CNT_WIDTH = 64
)
(
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 instret_i,
    input  logic                 cycle_we_i,
    input  logic                 instret_we_i,
    input  logic [CNT_WIDTH-1:0] wdata_i,
    output logic [CNT_WIDTH-1:0] cycle_cnt_o,
    output logic [CNT_WIDTH-1:0] instret_cnt_o
);

    // A software write replaces the increment for that cycle
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            cycle_cnt_o   <= '0;
            instret_cnt_o <= '0;
        end
        else
        begin
            cycle_cnt_o   <= cycle_we_i ? wdata_i : cycle_cnt_o + CNT_WIDTH'(1);
            instret_cnt_o <= instret_we_i ? wdata_i : instret_cnt_o + CNT_WIDTH'(instret_i);
        end
    end

endmodule

// File: src/csr_priv_fsm.sv
module csr_priv_fsm
(
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  logic                             csr_cmd_v_i,
    input  csr_unit_pkg::csr_op_e            csr_op_i,
    input  csr_unit_pkg::trap_req_s          trap_req_i,
    input  logic                             mstatus_we_i,
    input  logic [riscv_priv_pkg::XLEN-1:0]  wdata_i,
    input  logic                             addr_bad_i,
    output riscv_priv_pkg::priv_mode_e       priv_mode_o,
    output riscv_priv_pkg::mstatus_s         mstatus_o,
    output logic                             trap_v_o,
    output logic                             ret_v_o,
    output logic                             illegal_instr_o
);
    import riscv_priv_pkg::*;
    import csr_unit_pkg::*;

    priv_mode_e priv_mode_r, priv_mode_n;
    mstatus_s   mstatus_r, mstatus_n;
    mstatus_s   mstatus_wr;
    logic       is_mret;
    logic       mret_ok;

    assign mstatus_wr = wdata_i[12:0];
    assign is_mret    = csr_cmd_v_i & (csr_op_i == e_mret);
    assign mret_ok    = is_mret & (priv_mode_r == PRIV_M);

    assign illegal_instr_o = (is_mret & (priv_mode_r != PRIV_M)) | (csr_cmd_v_i & addr_bad_i);
    assign trap_v_o        = trap_req_i.valid;
    assign ret_v_o         = mret_ok & ~trap_req_i.valid;

    always_comb
    begin
        priv_mode_n = priv_mode_r;
        mstatus_n   = mstatus_r;

        if (mstatus_we_i)
        begin
            // Only U and M exist, anything else lands in U
            mstatus_n.mpp  = (mstatus_wr.mpp == PRIV_M) ? PRIV_M : PRIV_U;
            mstatus_n.mpie = mstatus_wr.mpie;
            mstatus_n.mie  = mstatus_wr.mie;
        end

        if (mret_ok)
        begin
            priv_mode_n    = priv_mode_e'(mstatus_r.mpp);
            mstatus_n.mie  = mstatus_r.mpie;
            mstatus_n.mpie = 1'b1;
            mstatus_n.mpp  = PRIV_U;
        end

        if (trap_req_i.valid)
        begin
            priv_mode_n    = PRIV_M;
            mstatus_n.mpp  = priv_mode_r;
            mstatus_n.mpie = mstatus_r.mie;
            mstatus_n.mie  = 1'b0;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            priv_mode_r <= PRIV_M;
            mstatus_r   <= '0;
        end
        else
        begin
            priv_mode_r <= priv_mode_n;
            mstatus_r   <= mstatus_n;
        end
    end

    assign priv_mode_o = priv_mode_r;
    assign mstatus_o   = mstatus_r;

endmodule

// File: src/csr_trap_cause.sv
module csr_trap_cause
(
    input  riscv_priv_pkg::priv_mode_e       priv_mode_i,
    input  riscv_priv_pkg::mstatus_s         mstatus_i,
    input  riscv_priv_pkg::mirq_s            mie_i,
    input  riscv_priv_pkg::mirq_s            mip_i,
    input  logic                             exc_v_i,
    input  csr_unit_pkg::exc_dec_s           exc_dec_i,
    input  logic [riscv_priv_pkg::XLEN-1:0]  exc_pc_i,
    input  logic [riscv_priv_pkg::XLEN-1:0]  irq_pc_i,
    output csr_unit_pkg::trap_req_s          trap_req_o
);
    import riscv_priv_pkg::*;
    import csr_unit_pkg::*;

    exc_dec_s   exc_q;
    logic [3:0] exc_code;
    logic       exc_found;
    mirq_s      irq_pend;
    logic       irq_found;
    logic [3:0] irq_code;

    // An ecall only counts for the mode it was issued from
    always_comb
    begin
        exc_q          = exc_dec_i;
        exc_q.ecall_u  = exc_dec_i.ecall_u & (priv_mode_i == PRIV_U);
        exc_q.ecall_m  = exc_dec_i.ecall_m & (priv_mode_i == PRIV_M);
        exc_q.rsv_10_9 = '0;
    end

    // Lowest set bit has the highest priority
    always_comb
    begin
        exc_code = '0;
        for (int i = 11; i >= 0; i--)
        begin
            if (exc_q[i])
            begin
                exc_code = 4'(i);
            end
        end
    end

    assign exc_found = exc_v_i & (|exc_q);

    assign irq_pend  = mie_i & mip_i;
    assign irq_found = ((priv_mode_i == PRIV_U) | mstatus_i.mie)
                     & (irq_pend.meip | irq_pend.msip | irq_pend.mtip);
    assign irq_code  = irq_pend.meip ? CAUSE_IRQ_MEXT
                     : irq_pend.msip ? CAUSE_IRQ_MSOFT
                     : CAUSE_IRQ_MTIMER;

    // Interrupt wins, but keeps the pc of a coincident exception
    always_comb
    begin
        trap_req_o.valid     = irq_found | exc_found;
        trap_req_o.interrupt = irq_found;
        trap_req_o.code      = irq_found ? irq_code : exc_code;
        trap_req_o.epc       = exc_found ? exc_pc_i : irq_pc_i;
        trap_req_o.tval      = irq_found ? '0 : exc_pc_i;
    end

endmodule

// File: src/csr_unit_pkg.sv
package csr_unit_pkg;

    typedef enum logic [2:0]
    {
        e_csrrw  = 3'd0,
        e_csrrs  = 3'd1,
        e_csrrc  = 3'd2,
        e_csrrwi = 3'd3,
        e_csrrsi = 3'd4,
        e_csrrci = 3'd5,
        e_mret   = 3'd6
    } csr_op_e;

    typedef struct packed {
        csr_op_e                          op;
        logic [11:0]                      addr;
        logic [riscv_priv_pkg::XLEN-1:0]  data;
    } csr_cmd_s;

    // Bit index equals the exception cause code
    typedef struct packed {
        logic       ecall_m;
        logic [1:0] rsv_10_9;
        logic       ecall_u;
        logic       store_fault;
        logic       store_misaligned;
        logic       load_fault;
        logic       load_misaligned;
        logic       breakpoint;
        logic       illegal_instr;
        logic       instr_fault;
        logic       instr_misaligned;
    } exc_dec_s;

    typedef struct packed {
        logic                             valid;
        logic                             interrupt;
        logic [3:0]                       code;
        logic [riscv_priv_pkg::XLEN-1:0]  epc;
        logic [riscv_priv_pkg::XLEN-1:0]  tval;
    } trap_req_s;

endpackage

// File: src/riscv_priv_pkg.sv
package riscv_priv_pkg;

    localparam int unsigned XLEN = 64;

    typedef enum logic [1:0]
    {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_mode_e;

    // Machine-mode CSR addresses
    localparam logic [11:0] CSR_ADDR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_ADDR_MIE      = 12'h304;
    localparam logic [11:0] CSR_ADDR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_ADDR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_ADDR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_ADDR_MCAUSE   = 12'h342;
    localparam logic [11:0] CSR_ADDR_MTVAL    = 12'h343;
    localparam logic [11:0] CSR_ADDR_MIP      = 12'h344;
    localparam logic [11:0] CSR_ADDR_MCYCLE   = 12'hB00;
    localparam logic [11:0] CSR_ADDR_MINSTRET = 12'hB02;
    localparam logic [11:0] CSR_ADDR_MHARTID  = 12'hF14;

    // Low 13 bits of mstatus, fields at their architectural positions
    typedef struct packed {
        logic [1:0] mpp;
        logic [2:0] rsv_10_8;
        logic       mpie;
        logic [2:0] rsv_6_4;
        logic       mie;
        logic [2:0] rsv_2_0;
    } mstatus_s;

    // Shared layout of mie and mip
    typedef struct packed {
        logic       meip;
        logic [2:0] rsv_10_8;
        logic       mtip;
        logic [2:0] rsv_6_4;
        logic       msip;
        logic [2:0] rsv_2_0;
    } mirq_s;

    typedef struct packed {
        logic        interrupt;
        logic [58:0] rsv;
        logic [3:0]  code;
    } mcause_s;

    localparam logic [3:0] CAUSE_IRQ_MSOFT  = 4'd3;
    localparam logic [3:0] CAUSE_IRQ_MTIMER = 4'd7;
    localparam logic [3:0] CAUSE_IRQ_MEXT   = 4'd11;

endpackage
